// File: hw/pm_pkg.sv
package pm_pkg;

  typedef enum logic [2:0] {
    PWR_DOWN  = 3'd0,
    PWR_RAMP  = 3'd1,
    PWR_CHECK = 3'd2,
    PWR_UP    = 3'd3,
    PWR_NONE  = 3'd4
  } pm_state_e;

  typedef enum logic [1:0] {
    CAUSE_COLD_START = 2'd0,
    CAUSE_CRASH      = 2'd1,
    CAUSE_WATCHDOG   = 2'd2,
    CAUSE_USER       = 2'd3
  } no_power_cause_e;

  typedef enum logic [15:0] {
    REG_STATE     = 16'd0, // cause and state
    REG_POWERUP   = 16'd1,
    REG_POWERDOWN = 16'd2, // zero means soft reset
    REG_CRASH     = 16'd3,
    REG_WD        = 16'd4,
    REG_CHS       = 16'd5,
    REG_PG        = 16'd6,
    REG_WD_CONF   = 16'd7
  } reg_addr_e;

  localparam int NUM_RAILS = 6; // rail 0 is the ATX enable

  localparam int POWER_DOWN_WAIT   = 16;
  localparam int POST_POWERUP_WAIT = 12;
  localparam int RAIL_STEP_WAIT    = 4;
  localparam int BUTTON_FORCE      = 48;
  localparam int WD_UNIT           = 32;

  localparam logic [2:0] MAX_CRASHES      = 3'd3;
  localparam logic [2:0] MAX_WD_OVERFLOWS = 3'd7;

  localparam int BTN_SAT      = BUTTON_FORCE + 1; // press timer ceiling
  localparam int BTN_W        = $clog2(BTN_SAT + 1);
  localparam int DOWN_WAIT_W  = $clog2(POWER_DOWN_WAIT + 1);
  localparam int CHECK_WAIT_W = $clog2(POST_POWERUP_WAIT + 1);
  localparam int RAIL_STEP_W  = $clog2(RAIL_STEP_WAIT + 1);
  localparam int WD_TICK_W    = $clog2(WD_UNIT);

  typedef struct packed {
    logic powerup;
    logic powerdown;
    logic soft_reset_req;
    logic crash_ack;
    logic wd_ack;
    logic chs_ack;
  } pm_cmd_t;

  typedef struct packed {
    pm_state_e       state;
    no_power_cause_e cause;
    logic [2:0]      crash_cnt;
    logic [2:0]      wd_cnt;
    logic            chs_pending;
    logic [4:0]      wd_conf;
  } pm_status_t;

endpackage

// File: hw/rail_sequencer.sv
`timescale 1ns/1ps

module rail_sequencer import pm_pkg::*; (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 ramp_up_i,
  input  logic [NUM_RAILS-1:0] pg_i,
  output logic [NUM_RAILS-1:0] rail_en_o,
  output logic                 ramp_done_o
);

  logic [NUM_RAILS-1:0]   rail_en_q; // thermometer code, rail 0 first
  logic [RAIL_STEP_W-1:0] step_q;
  logic                   all_on;
  logic                   all_off;
  logic                   pg_ok;

  assign all_on  = &rail_en_q;
  assign all_off = ~|rail_en_q;

  // every rail switched on so far reports good
  assign pg_ok = &(pg_i | ~rail_en_q);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      rail_en_q <= '0;
      step_q    <= '0;
    end else if (ramp_up_i ? all_on : all_off) begin
      step_q <= '0; // nothing left to do in this direction
    end else if (step_q != RAIL_STEP_W'(RAIL_STEP_WAIT - 1)) begin
      step_q <= step_q + 1'b1;
    end else if (!ramp_up_i) begin
      rail_en_q <= rail_en_q >> 1; // highest rail off first
      step_q    <= '0;
    end else if (pg_ok) begin
      rail_en_q <= {rail_en_q[NUM_RAILS-2:0], 1'b1};
      step_q    <= '0;
    end
  end

  assign rail_en_o   = rail_en_q;
  assign ramp_done_o = all_on && (&pg_i);

endmodule

// File: hw/button_ctrl.sv
`timescale 1ns/1ps

module button_ctrl import pm_pkg::*; (
  input  logic      wb_clk_i,
  input  logic      wb_rst_i,
  input  logic      button_i,
  input  pm_state_e state_i,
  output logic      btn_short_o,
  output logic      btn_force_o
);

  logic [BTN_W-1:0] press_q; // cycles held, saturating

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || !button_i) begin
      press_q <= '0;
    end else if (state_i == PWR_NONE) begin
      // one tick for the short press, then park at the ceiling
      press_q <= (press_q == '0) ? BTN_W'(1) : BTN_W'(BTN_SAT);
    end else if (press_q != BTN_W'(BTN_SAT)) begin
      press_q <= press_q + 1'b1;
    end
  end

  assign btn_short_o = press_q == BTN_W'(1); // second cycle of the press
  assign btn_force_o = press_q == BTN_W'(BUTTON_FORCE);

endmodule

// File: hw/fault_monitor.sv
`timescale 1ns/1ps

module fault_monitor import pm_pkg::*; (
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  input  pm_state_e  state_i,
  input  logic       crash_i,
  input  pm_cmd_t    cmd_i,
  input  logic [4:0] wd_conf_i,
  output logic       wd_overflow_o,
  output logic [2:0] crash_cnt_o,
  output logic [2:0] wd_cnt_o
);

  logic [WD_TICK_W-1:0] tick_q; // cycles within one unit
  logic [4:0]           unit_q; // whole units elapsed

  always_ff @(posedge wb_clk_i) begin
    wd_overflow_o <= 1'b0;
    if (wb_rst_i || state_i == PWR_NONE) begin
      tick_q   <= '0;
      unit_q   <= '0;
      wd_cnt_o <= '0;
    end else if (cmd_i.wd_ack) begin
      tick_q   <= '0; // kick
      unit_q   <= '0;
      wd_cnt_o <= '0;
    end else if (state_i != PWR_UP || wd_conf_i == '0) begin
      tick_q <= '0;
      unit_q <= '0;
    end else if (unit_q >= wd_conf_i) begin
      tick_q        <= '0;
      unit_q        <= '0;
      wd_overflow_o <= 1'b1;
      wd_cnt_o      <= wd_cnt_o + 1'b1;
    end else if (tick_q == WD_TICK_W'(WD_UNIT - 1)) begin
      tick_q <= '0;
      unit_q <= unit_q + 1'b1;
    end else begin
      tick_q <= tick_q + 1'b1;
    end
  end

  // a crash in the same cycle as the ack still counts
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      crash_cnt_o <= '0;
    end else begin
      if (cmd_i.crash_ack) begin
        crash_cnt_o <= '0;
      end
      if (crash_i) begin
        crash_cnt_o <= crash_cnt_o + 1'b1;
      end
    end
  end

endmodule

// File: hw/power_fsm.sv
`timescale 1ns/1ps

module power_fsm import pm_pkg::*; (
  input  logic            wb_clk_i,
  input  logic            wb_rst_i,
  input  pm_cmd_t         cmd_i,
  input  logic            cold_start_i,
  input  logic            dma_done_i,
  input  logic            chs_reset_i,
  input  logic            unsafe_health_i,
  input  logic            btn_short_i,
  input  logic            btn_force_i,
  input  logic            ramp_done_i,
  input  logic            wd_overflow_i,
  input  logic [2:0]      crash_cnt_i,
  input  logic [2:0]      wd_cnt_i,
  output logic            ramp_up_o,
  output pm_state_e       state_o,
  output no_power_cause_e cause_o,
  output logic            crash_o,
  output logic            soft_reset_o,
  output logic            chs_pending_o,
  output logic            power_on_o,
  output logic            power_ok_o,
  output logic            load_res_off_o
);

  pm_state_e               state_q;
  logic                    first_q; // first pass since reset
  logic [DOWN_WAIT_W-1:0]  down_wait_q;
  logic [CHECK_WAIT_W-1:0] check_wait_q;
  logic                    pre_pass;
  logic                    post_done;
  logic                    chs_pd; // acknowledged chassis power-down

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || state_q != PWR_DOWN) begin
      down_wait_q <= DOWN_WAIT_W'(POWER_DOWN_WAIT);
    end else if (down_wait_q != '0) begin
      down_wait_q <= down_wait_q - 1'b1;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || state_q != PWR_CHECK) begin
      check_wait_q <= CHECK_WAIT_W'(POST_POWERUP_WAIT - 1);
    end else if (check_wait_q != '0) begin
      check_wait_q <= check_wait_q - 1'b1;
    end
  end

  assign pre_pass  = (down_wait_q == '0) && dma_done_i;
  assign post_done = check_wait_q == '0;
  assign chs_pd    = chs_pending_o && cmd_i.chs_ack;

  always_ff @(posedge wb_clk_i) begin
    crash_o      <= 1'b0;
    soft_reset_o <= 1'b0;
    if (wb_rst_i) begin
      state_q      <= PWR_DOWN;
      cause_o      <= CAUSE_COLD_START;
      first_q      <= 1'b1;
      soft_reset_o <= 1'b1;
    end else begin
      case (state_q)
        PWR_DOWN: begin
          if (pre_pass) begin
            first_q <= 1'b0;
            if (cold_start_i && first_q) begin
              state_q <= PWR_NONE;
              cause_o <= CAUSE_COLD_START;
            end else begin
              state_q <= PWR_RAMP;
            end
          end
        end
        PWR_RAMP: begin
          if (ramp_done_i) begin
            state_q <= PWR_CHECK;
          end
        end
        PWR_CHECK: begin
          if (post_done && unsafe_health_i) begin
            crash_o      <= 1'b1;
            soft_reset_o <= 1'b1;
            if (crash_cnt_i == MAX_CRASHES) begin
              state_q <= PWR_NONE;
              cause_o <= CAUSE_CRASH;
            end else begin
              state_q <= PWR_DOWN;
            end
          end else if (post_done) begin
            state_q <= PWR_UP;
          end
        end
        PWR_UP: begin
          if (cmd_i.soft_reset_req || chs_reset_i) begin // lowest priority
            state_q      <= PWR_DOWN;
            soft_reset_o <= 1'b1;
          end
          if (wd_overflow_i) begin
            if (wd_cnt_i == MAX_WD_OVERFLOWS) begin
              state_q <= PWR_NONE;
              cause_o <= CAUSE_WATCHDOG;
            end else begin
              state_q      <= PWR_DOWN;
              soft_reset_o <= 1'b1;
            end
          end
          if (unsafe_health_i) begin
            crash_o      <= 1'b1;
            soft_reset_o <= 1'b1;
            if (crash_cnt_i == MAX_CRASHES) begin
              state_q <= PWR_NONE;
              cause_o <= CAUSE_CRASH;
            end else begin
              state_q <= PWR_DOWN;
            end
          end
          if (cmd_i.powerdown || chs_pd) begin // highest priority
            state_q <= PWR_NONE;
            cause_o <= CAUSE_USER;
          end
        end
        PWR_NONE: begin
          if ((btn_short_i || cmd_i.powerup) && dma_done_i) begin
            state_q      <= PWR_DOWN;
            soft_reset_o <= 1'b1;
          end
        end
        default: state_q <= PWR_DOWN;
      endcase
      // long press wins over everything while powered
      if (btn_force_i && state_q != PWR_NONE) begin
        state_q <= PWR_NONE;
        cause_o <= CAUSE_USER;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      chs_pending_o <= 1'b0;
    end else begin
      if (btn_short_i) begin
        chs_pending_o <= 1'b1;
      end
      if (chs_pd || state_q != PWR_UP) begin
        chs_pending_o <= 1'b0;
      end
    end
  end

  assign state_o        = state_q;
  assign ramp_up_o      = state_q inside {PWR_RAMP, PWR_CHECK, PWR_UP};
  assign power_on_o     = state_q inside {PWR_CHECK, PWR_UP};
  assign power_ok_o     = state_q == PWR_UP;
  assign load_res_off_o = (state_q inside {PWR_NONE, PWR_UP}) || wb_rst_i;

endmodule

// File: hw/pm_wb_regs.sv
`timescale 1ns/1ps

module pm_wb_regs import pm_pkg::*; (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [15:0]          wb_adr_i,
  input  logic [15:0]          wb_dat_i,
  output logic [15:0]          wb_dat_o,
  output logic                 wb_ack_o,
  input  pm_status_t           status_i,
  input  logic [NUM_RAILS-1:0] pg_i,
  output pm_cmd_t              cmd_o,
  output logic [4:0]           wd_conf_o
);

  logic        accept;
  logic [15:0] rd_data;

  assign accept = wb_cyc_i && wb_stb_i && !wb_ack_o; // ack low keeps acks apart

  always_comb begin
    case (reg_addr_e'(wb_adr_i))
      REG_STATE:   rd_data = {6'b0, status_i.cause, 5'b0, status_i.state};
      REG_CRASH:   rd_data = {13'b0, status_i.crash_cnt};
      REG_WD:      rd_data = {13'b0, status_i.wd_cnt};
      REG_CHS:     rd_data = {15'b0, status_i.chs_pending};
      REG_PG:      rd_data = {{(16 - NUM_RAILS){1'b0}}, pg_i};
      REG_WD_CONF: rd_data = {11'b0, status_i.wd_conf};
      default:     rd_data = '0; // write-only and unmapped
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o  <= 1'b0;
      cmd_o     <= '0;
      wd_conf_o <= '0; // watchdog off
    end else begin
      wb_ack_o <= accept;
      cmd_o    <= '0; // strobes last one cycle
      if (accept && wb_we_i) begin
        case (reg_addr_e'(wb_adr_i))
          REG_POWERUP: begin
            cmd_o.powerup <= |wb_dat_i;
          end
          REG_POWERDOWN: begin
            cmd_o.powerdown      <= |wb_dat_i;
            cmd_o.soft_reset_req <= ~|wb_dat_i;
          end
          REG_CRASH: begin
            cmd_o.crash_ack <= 1'b1;
          end
          REG_WD: begin
            cmd_o.wd_ack <= 1'b1; // also kicks the timer
          end
          REG_CHS: begin
            cmd_o.chs_ack <= 1'b1;
          end
          REG_WD_CONF: begin
            wd_conf_o <= wb_dat_i[4:0];
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      wb_dat_o <= rd_data; // valid in the ack cycle
    end
  end

endmodule

// File: hw/power_manager.sv
`timescale 1ns/1ps

module power_manager import pm_pkg::*; (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [15:0]          wb_adr_i,
  input  logic [15:0]          wb_dat_i,
  output logic [15:0]          wb_dat_o,
  output logic                 wb_ack_o,
  input  logic                 cold_start_i,
  input  logic                 dma_done_i,
  input  logic                 button_i,
  input  logic                 chs_reset_i,
  input  logic                 unsafe_health_i,
  input  logic [NUM_RAILS-1:0] pg_i,
  output logic [NUM_RAILS-1:0] rail_en_o,
  output logic                 power_on_o,
  output logic                 power_ok_o,
  output logic                 crash_o,
  output logic                 soft_reset_o,
  output logic                 chs_pending_o,
  output logic                 load_res_off_o,
  output no_power_cause_e      cause_o
);

  pm_cmd_t    cmd;
  pm_status_t status;
  pm_state_e  pm_state;
  logic [4:0] wd_conf;
  logic [2:0] crash_cnt;
  logic [2:0] wd_cnt;
  logic       ramp_up;
  logic       ramp_done;
  logic       btn_short;
  logic       btn_force;
  logic       wd_overflow;

  assign status = '{state:       pm_state,
                    cause:       cause_o,
                    crash_cnt:   crash_cnt,
                    wd_cnt:      wd_cnt,
                    chs_pending: chs_pending_o,
                    wd_conf:     wd_conf};

  pm_wb_regs regs_i (
    .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i,
    .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .status_i (status),
    .pg_i,
    .cmd_o    (cmd),
    .wd_conf_o(wd_conf)
  );

  power_fsm fsm_i (
    .wb_clk_i, .wb_rst_i,
    .cmd_i        (cmd),
    .cold_start_i, .dma_done_i, .chs_reset_i, .unsafe_health_i,
    .btn_short_i  (btn_short),
    .btn_force_i  (btn_force),
    .ramp_done_i  (ramp_done),
    .wd_overflow_i(wd_overflow),
    .crash_cnt_i  (crash_cnt),
    .wd_cnt_i     (wd_cnt),
    .ramp_up_o    (ramp_up),
    .state_o      (pm_state),
    .cause_o, .crash_o, .soft_reset_o, .chs_pending_o,
    .power_on_o, .power_ok_o, .load_res_off_o
  );

  rail_sequencer rails_i (
    .wb_clk_i, .wb_rst_i,
    .ramp_up_i  (ramp_up),
    .pg_i,
    .rail_en_o,
    .ramp_done_o(ramp_done)
  );

  button_ctrl button_i_ctrl (
    .wb_clk_i, .wb_rst_i, .button_i,
    .state_i    (pm_state),
    .btn_short_o(btn_short),
    .btn_force_o(btn_force)
  );

  fault_monitor faults_i (
    .wb_clk_i, .wb_rst_i,
    .state_i      (pm_state),
    .crash_i      (crash_o),
    .cmd_i        (cmd),
    .wd_conf_i    (wd_conf),
    .wd_overflow_o(wd_overflow),
    .crash_cnt_o  (crash_cnt),
    .wd_cnt_o     (wd_cnt)
  );

endmodule

// File: dv/power_manager_props.sv
`timescale 1ns/1ps

module power_manager_props import pm_pkg::*; (
  input logic                 wb_clk_i,
  input logic                 wb_rst_i,
  input logic                 wb_cyc_i,
  input logic                 wb_stb_i,
  input logic                 wb_ack_o,
  input logic                 power_ok_o,
  input logic [NUM_RAILS-1:0] rail_en_o,
  input pm_state_e            pm_state
);

  localparam int RAMP_DOWN_CYCLES = NUM_RAILS * RAIL_STEP_WAIT + 1;

  ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o) else $error("ack high in two consecutive cycles");

  ok_rails_on: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    power_ok_o |-> &rail_en_o) else $error("power ok with a rail disabled");

  none_rails_off: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (pm_state == PWR_NONE) [*RAMP_DOWN_CYCLES] |-> rail_en_o == '0)
    else $error("rails still enabled after ramp-down in no-power state");

  one_ack_per_strobe: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o ##1 !wb_ack_o)
    else $error("access not answered by exactly one ack");

endmodule

bind power_manager power_manager_props props_i (
  .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_ack_o,
  .power_ok_o, .rail_en_o, .pm_state
);

// File: dv/power_manager_tb.sv
`timescale 1ns/1ps

module power_manager_tb import pm_pkg::*; ();

  localparam int RAMP_LEN = POWER_DOWN_WAIT + NUM_RAILS * (RAIL_STEP_WAIT + 4) + POST_POWERUP_WAIT;
  localparam int TIMEOUT_CYCLES = 20 * (RAMP_LEN + 20) + 8 * 31 * WD_UNIT + 4 * BUTTON_FORCE;

  logic wb_clk_i = 1'b0;
  logic wb_rst_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  logic [15:0] wb_adr_i, wb_dat_i, wb_dat_o;
  logic cold_start_i, dma_done_i, button_i, chs_reset_i, unsafe_health_i;
  logic [NUM_RAILS-1:0] pg_i, pg_d, rail_en_o;
  logic power_on_o, power_ok_o, crash_o, soft_reset_o, chs_pending_o, load_res_off_o;
  no_power_cause_e cause_o;

  pm_state_e m_state; // reference model of the status
  no_power_cause_e m_cause;
  logic [2:0] m_crash, m_wd;
  logic [4:0] m_conf;
  logic m_chs;
  logic [15:0] exp_q[$], got_q[$];
  int unsigned lcg_state = 79212;
  int cycles = 0;
  int errors = 0;
  int conf;
  int dly;

  power_manager dut_i (.*);

  always #2 wb_clk_i = ~wb_clk_i;

  always @(posedge wb_clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the DUT never reached the expected state");
      $display("Something failed");
      $fatal(1);
    end
  end

  function automatic int unsigned lcg_next();
    lcg_state = (lcg_state * 1103515245 + 12345) % 32'h8000_0000;
    return lcg_state >> 8;
  endfunction

  // expected register contents from the model
  function automatic logic [15:0] ref_read(input reg_addr_e a);
    case (a)
      REG_STATE:   return {6'b0, m_cause, 5'b0, m_state};
      REG_CRASH:   return {13'b0, m_crash};
      REG_WD:      return {13'b0, m_wd};
      REG_CHS:     return {15'b0, m_chs};
      REG_PG:      return {{(16 - NUM_RAILS){1'b0}}, {NUM_RAILS{1'b1}}}; // read only in PWR_UP
      REG_WD_CONF: return {11'b0, m_conf};
      default:     return 16'h0;
    endcase
  endfunction

  // a fault at its count limit leaves no power, else restart
  function automatic pm_state_e ref_fault_next(input logic [2:0] cnt, input logic [2:0] lim);
    return (cnt == lim) ? PWR_NONE : PWR_DOWN;
  endfunction

  task automatic check(input logic [15:0] got, input logic [15:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // compare process for bus reads
  initial begin
    forever begin
      @(posedge wb_clk_i);
      while (got_q.size() != 0) begin
        check(got_q.pop_front(), exp_q.pop_front(), "read data");
      end
    end
  end

  // pg follows the rail enables two cycles late
  always @(negedge wb_clk_i) begin
    pg_d <= rail_en_o;
    pg_i <= pg_d;
    check(16'((rail_en_o & NUM_RAILS'(rail_en_o + 1'b1)) != 0), 16'h0, "rail order");
  end

  task automatic bus_access(input logic we, input logic [15:0] adr, input logic [15:0] dat,
                            output logic [15:0] rdat);
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    do @(negedge wb_clk_i); while (!wb_ack_o);
    rdat = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic bus_write(input reg_addr_e adr, input logic [15:0] dat);
    logic [15:0] unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic bus_read(input reg_addr_e adr);
    logic [15:0] rdat;
    exp_q.push_back(ref_read(adr));
    bus_access(1'b0, adr, 16'h0, rdat);
    got_q.push_back(rdat);
  endtask

  task automatic wait_state(input pm_state_e s);
    while (dut_i.pm_state != s) @(negedge wb_clk_i);
    m_state = s;
    check(cause_o, m_cause, "cause");
    check(power_ok_o, s == PWR_UP, "power ok");
    check(power_on_o, s == PWR_UP, "power on");
  endtask

  task automatic reset_dut(input logic cold);
    cold_start_i = cold;
    wb_rst_i = 1'b1;
    repeat (2) @(negedge wb_clk_i);
    check(load_res_off_o, 1'b1, "load resistor in reset");
    check(rail_en_o, 16'h0, "rails in reset");
    wb_rst_i = 1'b0;
    check(soft_reset_o, 1'b1, "soft reset after reset");
    check(wb_ack_o | chs_pending_o | crash_o, 1'b0, "idle outputs after reset");
    m_cause = CAUSE_COLD_START;
    m_crash = '0;
    m_wd = '0;
    m_conf = '0;
    m_chs = 1'b0;
    wait_state(PWR_DOWN);
  endtask

  task automatic press(input int n);
    @(negedge wb_clk_i);
    button_i = 1'b1;
    repeat (n) @(negedge wb_clk_i);
    button_i = 1'b0;
  endtask

  initial begin
    {wb_cyc_i, wb_stb_i, wb_we_i, button_i, chs_reset_i, unsafe_health_i} = '0;
    {wb_adr_i, wb_dat_i} = '0;
    pg_i = '0;
    pg_d = '0;
    dma_done_i = 1'b1;
    // normal power-up
    reset_dut(1'b0);
    wait_state(PWR_UP);
    bus_read(REG_STATE);
    bus_read(REG_PG);
    // cold start
    reset_dut(1'b1);
    wait_state(PWR_NONE);
    bus_read(REG_STATE);
    bus_write(REG_POWERUP, 16'h1);
    wait_state(PWR_UP);
    // crash path up to the limit
    repeat (MAX_CRASHES + 1) begin
      dly = lcg_next() % 8;
      repeat (dly) @(negedge wb_clk_i);
      unsafe_health_i = 1'b1;
      @(negedge wb_clk_i);
      unsafe_health_i = 1'b0;
      check({crash_o, soft_reset_o}, 2'b11, "crash strobes");
      m_state = ref_fault_next(m_crash, MAX_CRASHES);
      m_crash++;
      if (m_state == PWR_NONE) m_cause = CAUSE_CRASH;
      wait_state(m_state);
      if (m_state == PWR_DOWN) wait_state(PWR_UP);
      bus_read(REG_CRASH);
    end
    bus_read(REG_STATE);
    bus_write(REG_CRASH, 16'h0);
    m_crash = '0;
    bus_read(REG_CRASH);
    bus_write(REG_POWERUP, 16'h5);
    wait_state(PWR_UP);
    // watchdog overflow, acknowledge and kicks
    conf = 1 + lcg_next() % 3;
    bus_write(REG_WD_CONF, 16'(conf));
    m_conf = 5'(conf);
    bus_read(REG_WD_CONF);
    m_state = ref_fault_next(m_wd, MAX_WD_OVERFLOWS);
    m_wd++;
    wait_state(m_state);
    wait_state(PWR_UP);
    bus_read(REG_WD);
    bus_write(REG_WD, 16'h1);
    m_wd = '0;
    bus_read(REG_WD);
    repeat (4) begin
      repeat (conf * WD_UNIT / 2) @(negedge wb_clk_i);
      bus_write(REG_WD, 16'h0);
      check(dut_i.pm_state, PWR_UP, "state while kicked");
    end
    bus_write(REG_WD_CONF, 16'h0);
    m_conf = '0;
    // user controls
    bus_write(REG_POWERDOWN, 16'h0);
    wait_state(PWR_DOWN);
    wait_state(PWR_UP);
    bus_write(REG_POWERDOWN, 16'h1);
    m_cause = CAUSE_USER;
    wait_state(PWR_NONE);
    bus_read(REG_STATE);
    bus_write(REG_POWERUP, 16'h1);
    wait_state(PWR_UP);
    // power button
    press(3);
    m_chs = 1'b1; // short press in PWR_UP
    while (!chs_pending_o) @(negedge wb_clk_i);
    bus_read(REG_CHS);
    bus_write(REG_CHS, 16'h1);
    wait_state(PWR_NONE);
    m_chs = 1'b0;
    bus_read(REG_CHS);
    press(3);
    wait_state(PWR_DOWN);
    wait_state(PWR_UP);
    @(negedge wb_clk_i);
    button_i = 1'b1; // long press
    wait_state(PWR_NONE);
    button_i = 1'b0;
    bus_read(REG_STATE);
    while (got_q.size() != 0) @(negedge wb_clk_i);
    @(negedge wb_clk_i);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: power_manager.f
hw/pm_pkg.sv
hw/rail_sequencer.sv
hw/button_ctrl.sv
hw/fault_monitor.sv
hw/power_fsm.sv
hw/pm_wb_regs.sv
hw/power_manager.sv
dv/power_manager_props.sv
dv/power_manager_tb.sv
